// ==== dv/convacc_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "convacc_params.svh"

module convacc_tb;

  import convacc_pkg::*;
  import sram_bus_pkg::*;

  localparam int NUM_TESTS      = 8;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 200;
  localparam int DIM            = `FMAP_DIM;
  localparam int HALF           = `FMAP_DIM / 2;

  // Mode, weight, flat input map and second start while busy per case
  localparam layer_mode_e TBL_MODE [NUM_TESTS] = '{
    MODE_CONV_1X1, MODE_CONV_1X1, MODE_CONV_1X1, MODE_MAX_POOL,
    MODE_MAX_POOL, MODE_IDLE, MODE_CONV_1X1, MODE_MAX_POOL
  };
  localparam int TBL_WEIGHT [NUM_TESTS] = '{3, 0, 255, 0, 0, 0, 7, 0};
  localparam bit TBL_FLAT [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
  localparam bit TBL_DOUBLE [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};

  logic        clk;
  logic        rst;
  layer_mode_e mode;
  logic        start;
  logic        busy;
  logic        done;
  logic        in_cs, in_oe, in_w_req;
  logic        wt_cs, wt_oe, wt_w_req;
  logic        out_cs, out_oe, out_w_req;
  sram_addr_t  in_addr, wt_addr, out_addr;
  sram_data_t  in_w_data, wt_w_data, out_w_data;
  sram_data_t  in_r_data = '0;
  sram_data_t  wt_r_data = '0;
  sram_data_t  out_r_data = '0;

  sram_data_t  in_mem  [256];
  sram_data_t  wt_mem  [256];
  sram_data_t  out_mem [256];
  logic        clear_out;

  int seed = 86598;
  int errs = 0;
  int pass_count = 0;
  int fail_count = 0;
  int cycle_count = 0;
  int in_act = 0;
  int wt_act = 0;
  int out_act = 0;
  int misuse_count = 0;
  int done_count = 0;

  convacc_top u_convacc_top (
    .clk          (clk),
    .rst_i        (rst),
    .mode_i       (mode),
    .start_i      (start),
    .busy_o       (busy),
    .done_o       (done),
    .in_cs_o      (in_cs),
    .in_oe_o      (in_oe),
    .in_w_req_o   (in_w_req),
    .in_addr_o    (in_addr),
    .in_w_data_o  (in_w_data),
    .in_r_data_i  (in_r_data),
    .wt_cs_o      (wt_cs),
    .wt_oe_o      (wt_oe),
    .wt_w_req_o   (wt_w_req),
    .wt_addr_o    (wt_addr),
    .wt_w_data_o  (wt_w_data),
    .wt_r_data_i  (wt_r_data),
    .out_cs_o     (out_cs),
    .out_oe_o     (out_oe),
    .out_w_req_o  (out_w_req),
    .out_addr_o   (out_addr),
    .out_w_data_o (out_w_data),
    .out_r_data_i (out_r_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Synchronous SRAMs return read data one cycle after the request
  always @(posedge clk) begin
    if (in_cs && in_oe) begin
      in_r_data <= in_mem[in_addr];
    end
    if (wt_cs && wt_oe) begin
      wt_r_data <= wt_mem[wt_addr];
    end
    if (out_cs && out_oe) begin
      out_r_data <= out_mem[out_addr];
    end
  end

  // Output SRAM capture with an address fill cleared in before each run
  always @(posedge clk) begin
    if (clear_out) begin
      for (int a = 0; a < 256; a++) begin
        out_mem[a] <= sram_data_t'(32'hDE00 | a);
      end
    end else if (out_cs && out_w_req) begin
      out_mem[out_addr] <= out_w_data;
    end
  end

  // Bus activity and done counters
  always @(posedge clk) begin
    if (in_cs || in_oe || in_w_req) begin
      in_act <= in_act + 1;
    end
    if (wt_cs || wt_oe || wt_w_req) begin
      wt_act <= wt_act + 1;
    end
    if (out_cs || out_oe || out_w_req) begin
      out_act <= out_act + 1;
    end
    // Input and weight buses are read only and the output bus is write only
    if (in_w_req || wt_w_req || out_oe || in_w_data != '0 || wt_w_data != '0) begin
      misuse_count <= misuse_count + 1;
    end
    if (done) begin
      done_count <= done_count + 1;
    end
  end

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  function automatic string mode_label(input layer_mode_e m);
    case (m)
      MODE_CONV_1X1: return "conv_1x1";
      MODE_MAX_POOL: return "max_pool";
      default:       return "idle";
    endcase
  endfunction

  // Low 16 bits of the unsigned product
  function automatic sram_data_t conv_expected(input int idx, input int weight);
    int prod;
    prod = int'(in_mem[idx]) * weight;
    return sram_data_t'(prod);
  endfunction

  function automatic sram_data_t pool_expected(input int orow, input int ocol);
    sram_data_t best;
    sram_data_t v;
    best = '0;
    for (int dr = 0; dr < 2; dr++) begin
      for (int dc = 0; dc < 2; dc++) begin
        v = in_mem[(2 * orow + dr) * DIM + 2 * ocol + dc];
        if (v > best) begin
          best = v;
        end
      end
    end
    return best;
  endfunction

  task automatic load_memories(input int t);
    for (int a = 0; a < 256; a++) begin
      if (TBL_FLAT[t]) begin
        in_mem[a] = 16'h005A;
      end else begin
        in_mem[a] = sram_data_t'($random(seed) & 32'h0000_00FF);
      end
      wt_mem[a] = sram_data_t'(32'hC300 | a);
    end
    wt_mem[0] = sram_data_t'(TBL_WEIGHT[t]);
    clear_out = 1'b1;
    @(negedge clk);
    clear_out = 1'b0;
    @(negedge clk);
  endtask

  task automatic pulse_start(input layer_mode_e m);
    mode  = m;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_for_done(output bit seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < 200) begin
      @(negedge clk);
      seen = done;
      n++;
    end
  endtask

  task automatic compare_word(input int addr, input sram_data_t expected);
    if (out_mem[addr] !== expected) begin
      $display("FAIL t=%0t out_mem[%0d] expected %h got %h",
               $time, addr, expected, out_mem[addr]);
      errs++;
    end
  endtask

  task automatic expect_low(input string name, input logic value);
    if (value !== 1'b0) begin
      $display("FAIL t=%0t %s expected 0 got %b", $time, name, value);
      errs++;
    end
  endtask

  task automatic record_result(input string label);
    if (errs == 0) begin
      $display("%s: ok", label);
      pass_count++;
    end else begin
      $display("%s: %0d errors", label, errs);
      fail_count++;
    end
  endtask

  initial begin
    bit seen;
    int snap_done;
    int snap_in;
    int snap_wt;
    int snap_out;
    int snap_misuse;
    rst       = 1'b1;
    mode      = MODE_IDLE;
    start     = 1'b0;
    clear_out = 1'b0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    errs = 0;
    expect_low("busy_o", busy);
    expect_low("done_o", done);
    expect_low("in_cs_o", in_cs);
    expect_low("in_oe_o", in_oe);
    expect_low("in_w_req_o", in_w_req);
    expect_low("wt_cs_o", wt_cs);
    expect_low("wt_oe_o", wt_oe);
    expect_low("wt_w_req_o", wt_w_req);
    expect_low("out_cs_o", out_cs);
    expect_low("out_oe_o", out_oe);
    expect_low("out_w_req_o", out_w_req);
    record_result("reset state");

    for (int t = 0; t < NUM_TESTS; t++) begin
      errs = 0;
      load_memories(t);
      snap_done   = done_count;
      snap_in     = in_act;
      snap_wt     = wt_act;
      snap_out    = out_act;
      snap_misuse = misuse_count;
      pulse_start(TBL_MODE[t]);
      if (TBL_DOUBLE[t]) begin
        repeat (3) @(negedge clk);
        if (busy !== 1'b1) begin
          $display("busy_o was low three cycles after start at t=%0t", $time);
          errs++;
        end
        // Second start asks for the other unit
        pulse_start(TBL_MODE[t] == MODE_CONV_1X1 ? MODE_MAX_POOL : MODE_CONV_1X1);
      end

      if (TBL_MODE[t] == MODE_IDLE) begin
        repeat (100) @(negedge clk);
        if (done_count != snap_done) begin
          $display("done_o pulsed after a start in idle mode");
          errs++;
        end
        if (in_act != snap_in || wt_act != snap_wt || out_act != snap_out) begin
          $display("SRAM bus activity after a start in idle mode");
          errs++;
        end
        expect_low("busy_o", busy);
      end else begin
        wait_for_done(seen);
        if (!seen) begin
          $display("No done_o within 200 cycles of start at t=%0t", $time);
          errs++;
        end
        // Room for a stray second done
        repeat (10) @(negedge clk);
        if (done_count - snap_done != 1) begin
          $display("Expected one done_o pulse, saw %0d", done_count - snap_done);
          errs++;
        end
        expect_low("busy_o", busy);
        if (TBL_MODE[t] == MODE_CONV_1X1) begin
          for (int i = 0; i < DIM * DIM; i++) begin
            compare_word(i, conv_expected(i, TBL_WEIGHT[t]));
          end
        end else begin
          for (int r = 0; r < HALF; r++) begin
            for (int c = 0; c < HALF; c++) begin
              compare_word(r * HALF + c, pool_expected(r, c));
            end
          end
          if (wt_act != snap_wt) begin
            $display("Weight bus was active during pooling");
            errs++;
          end
        end
      end
      if (misuse_count != snap_misuse) begin
        $display("Write seen on the input or weight bus, or a read on the output bus");
        errs++;
      end
      record_result($sformatf("test %0d %s weight=%0d", t, mode_label(TBL_MODE[t]),
                              TBL_WEIGHT[t]));
    end

    $display("tests passed=%0d failed=%0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/conv_1x1_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "convacc_params.svh"

module conv_1x1_unit (
  input  wire logic                      clk,
  input  wire logic                      rst_i,
  input  wire logic                      en_i,
  input  wire logic                      start_i,
  output logic                           done_o,
  output logic                           wt_cs_o,
  output logic                           wt_oe_o,
  output sram_bus_pkg::sram_addr_t       wt_addr_o,
  input  wire sram_bus_pkg::sram_data_t  wt_r_data_i,
  output logic                           in_cs_o,
  output logic                           in_oe_o,
  output sram_bus_pkg::sram_addr_t       in_addr_o,
  input  wire sram_bus_pkg::sram_data_t  in_r_data_i,
  output logic                           out_cs_o,
  output logic                           out_w_req_o,
  output sram_bus_pkg::sram_addr_t       out_addr_o,
  output sram_bus_pkg::sram_data_t       out_w_data_o
);

  import convacc_pkg::*;
  import sram_bus_pkg::*;

  localparam int unsigned NUM_PIX  = `FMAP_DIM * `FMAP_DIM;
  localparam sram_addr_t  LAST_PIX = sram_addr_t'(NUM_PIX - 1);

  conv_state_e state_q;
  sram_addr_t  pix_idx_q;
  sram_data_t  weight_q;
  sram_data_t  pixel_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= S_IDLE;
      pix_idx_q <= '0;
      done_o    <= 1'b0;
    end else if (en_i) begin
      done_o <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            pix_idx_q <= '0;
            state_q   <= S_WREAD;
          end
        end
        S_WREAD: state_q <= S_WWAIT;
        S_WWAIT: state_q <= S_PREAD;
        S_PREAD: state_q <= S_PWAIT;
        S_PWAIT: state_q <= S_WRITE;
        S_WRITE: begin
          if (pix_idx_q == LAST_PIX) begin
            state_q <= S_IDLE;
            done_o  <= 1'b1;
          end else begin
            pix_idx_q <= pix_idx_q + 1'b1;
            state_q   <= S_PREAD;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Read data is valid in the wait states
  always_ff @(posedge clk) begin
    if (en_i && state_q == S_WWAIT) begin
      weight_q <= wt_r_data_i;
    end
    if (en_i && state_q == S_PWAIT) begin
      pixel_q <= in_r_data_i;
    end
  end

  // Single weight lives at address 0
  assign wt_cs_o   = (state_q == S_WREAD);
  assign wt_oe_o   = (state_q == S_WREAD);
  assign wt_addr_o = '0;

  assign in_cs_o   = (state_q == S_PREAD);
  assign in_oe_o   = (state_q == S_PREAD);
  assign in_addr_o = pix_idx_q;

  // Low half of the unsigned product
  assign out_cs_o     = (state_q == S_WRITE);
  assign out_w_req_o  = (state_q == S_WRITE);
  assign out_addr_o   = pix_idx_q;
  assign out_w_data_o = pixel_q * weight_q;

endmodule

`default_nettype wire

// ==== logic/conv_bus_switcher.sv ====
`timescale 1ns/1ns
`default_nettype none

module conv_bus_switcher (
  input  wire logic                      clk,
  input  wire logic                      rst_i,
  input  wire convacc_pkg::layer_mode_e  mode_i,
  input  wire logic                      start_i,
  output logic                           done_o,
  // External SRAM buses
  output logic                           ext_in_cs_o,
  output logic                           ext_in_oe_o,
  output logic                           ext_in_w_req_o,
  output sram_bus_pkg::sram_addr_t       ext_in_addr_o,
  output sram_bus_pkg::sram_data_t       ext_in_w_data_o,
  input  wire sram_bus_pkg::sram_data_t  ext_in_r_data_i,
  output logic                           ext_wt_cs_o,
  output logic                           ext_wt_oe_o,
  output logic                           ext_wt_w_req_o,
  output sram_bus_pkg::sram_addr_t       ext_wt_addr_o,
  output sram_bus_pkg::sram_data_t       ext_wt_w_data_o,
  input  wire sram_bus_pkg::sram_data_t  ext_wt_r_data_i,
  output logic                           ext_out_cs_o,
  output logic                           ext_out_oe_o,
  output logic                           ext_out_w_req_o,
  output sram_bus_pkg::sram_addr_t       ext_out_addr_o,
  output sram_bus_pkg::sram_data_t       ext_out_w_data_o,
  input  wire sram_bus_pkg::sram_data_t  ext_out_r_data_i,
  // 1x1 conv unit
  output logic                           conv_en_o,
  output logic                           conv_start_o,
  input  wire logic                      conv_done_i,
  input  wire logic                      conv_in_cs_i,
  input  wire logic                      conv_in_oe_i,
  input  wire logic                      conv_in_w_req_i,
  input  wire sram_bus_pkg::sram_addr_t  conv_in_addr_i,
  input  wire sram_bus_pkg::sram_data_t  conv_in_w_data_i,
  output sram_bus_pkg::sram_data_t       conv_in_r_data_o,
  input  wire logic                      conv_wt_cs_i,
  input  wire logic                      conv_wt_oe_i,
  input  wire logic                      conv_wt_w_req_i,
  input  wire sram_bus_pkg::sram_addr_t  conv_wt_addr_i,
  input  wire sram_bus_pkg::sram_data_t  conv_wt_w_data_i,
  output sram_bus_pkg::sram_data_t       conv_wt_r_data_o,
  input  wire logic                      conv_out_cs_i,
  input  wire logic                      conv_out_oe_i,
  input  wire logic                      conv_out_w_req_i,
  input  wire sram_bus_pkg::sram_addr_t  conv_out_addr_i,
  input  wire sram_bus_pkg::sram_data_t  conv_out_w_data_i,
  output sram_bus_pkg::sram_data_t       conv_out_r_data_o,
  // Max pooling unit
  output logic                           pool_en_o,
  output logic                           pool_start_o,
  input  wire logic                      pool_done_i,
  input  wire logic                      pool_in_cs_i,
  input  wire logic                      pool_in_oe_i,
  input  wire logic                      pool_in_w_req_i,
  input  wire sram_bus_pkg::sram_addr_t  pool_in_addr_i,
  input  wire sram_bus_pkg::sram_data_t  pool_in_w_data_i,
  output sram_bus_pkg::sram_data_t       pool_in_r_data_o,
  input  wire logic                      pool_out_cs_i,
  input  wire logic                      pool_out_oe_i,
  input  wire logic                      pool_out_w_req_i,
  input  wire sram_bus_pkg::sram_addr_t  pool_out_addr_i,
  input  wire sram_bus_pkg::sram_data_t  pool_out_w_data_i,
  output sram_bus_pkg::sram_data_t       pool_out_r_data_o
);

  import convacc_pkg::*;

  logic start_q;

  // One-hot unit enables that are both low in idle
  assign conv_en_o = (mode_i == MODE_CONV_1X1);
  assign pool_en_o = (mode_i == MODE_MAX_POOL);

  // Start waits one cycle so the latched mode has settled
  always_ff @(posedge clk) begin
    if (rst_i) begin
      start_q <= 1'b0;
    end else begin
      start_q <= start_i;
    end
  end

  assign conv_start_o = start_q & conv_en_o;
  assign pool_start_o = start_q & pool_en_o;
  assign done_o       = (conv_en_o & conv_done_i) | (pool_en_o & pool_done_i);

  // Input bus
  always_comb begin
    ext_in_cs_o      = 1'b0;
    ext_in_oe_o      = 1'b0;
    ext_in_w_req_o   = 1'b0;
    ext_in_addr_o    = '0;
    ext_in_w_data_o  = '0;
    conv_in_r_data_o = '0;
    pool_in_r_data_o = '0;
    if (conv_en_o) begin
      ext_in_cs_o      = conv_in_cs_i;
      ext_in_oe_o      = conv_in_oe_i;
      ext_in_w_req_o   = conv_in_w_req_i;
      ext_in_addr_o    = conv_in_addr_i;
      ext_in_w_data_o  = conv_in_w_data_i;
      conv_in_r_data_o = ext_in_r_data_i;
    end else if (pool_en_o) begin
      ext_in_cs_o      = pool_in_cs_i;
      ext_in_oe_o      = pool_in_oe_i;
      ext_in_w_req_o   = pool_in_w_req_i;
      ext_in_addr_o    = pool_in_addr_i;
      ext_in_w_data_o  = pool_in_w_data_i;
      pool_in_r_data_o = ext_in_r_data_i;
    end
  end

  // Weight bus belongs to the conv unit alone
  always_comb begin
    ext_wt_cs_o      = 1'b0;
    ext_wt_oe_o      = 1'b0;
    ext_wt_w_req_o   = 1'b0;
    ext_wt_addr_o    = '0;
    ext_wt_w_data_o  = '0;
    conv_wt_r_data_o = '0;
    if (conv_en_o) begin
      ext_wt_cs_o      = conv_wt_cs_i;
      ext_wt_oe_o      = conv_wt_oe_i;
      ext_wt_w_req_o   = conv_wt_w_req_i;
      ext_wt_addr_o    = conv_wt_addr_i;
      ext_wt_w_data_o  = conv_wt_w_data_i;
      conv_wt_r_data_o = ext_wt_r_data_i;
    end
  end

  // Output bus
  always_comb begin
    ext_out_cs_o      = 1'b0;
    ext_out_oe_o      = 1'b0;
    ext_out_w_req_o   = 1'b0;
    ext_out_addr_o    = '0;
    ext_out_w_data_o  = '0;
    conv_out_r_data_o = '0;
    pool_out_r_data_o = '0;
    if (conv_en_o) begin
      ext_out_cs_o      = conv_out_cs_i;
      ext_out_oe_o      = conv_out_oe_i;
      ext_out_w_req_o   = conv_out_w_req_i;
      ext_out_addr_o    = conv_out_addr_i;
      ext_out_w_data_o  = conv_out_w_data_i;
      conv_out_r_data_o = ext_out_r_data_i;
    end else if (pool_en_o) begin
      ext_out_cs_o      = pool_out_cs_i;
      ext_out_oe_o      = pool_out_oe_i;
      ext_out_w_req_o   = pool_out_w_req_i;
      ext_out_addr_o    = pool_out_addr_i;
      ext_out_w_data_o  = pool_out_w_data_i;
      pool_out_r_data_o = ext_out_r_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/convacc_params.svh ====
`ifndef CONVACC_PARAMS_SVH
`define CONVACC_PARAMS_SVH

// Side of the square input feature map
`define FMAP_DIM 4

// External SRAM bus widths
`define SRAM_AW 8
`define SRAM_DW 16

`endif

// ==== logic/convacc_pkg.sv ====
`default_nettype none

package convacc_pkg;

  // Layer mode picked by the host
  typedef enum logic [1:0] {
    MODE_IDLE     = 2'd0,
    MODE_CONV_1X1 = 2'd1,
    MODE_MAX_POOL = 2'd2
  } layer_mode_e;

  // 1x1 conv weight fetch then read/wait/write per pixel
  typedef enum logic [2:0] {
    S_IDLE,
    S_WREAD,
    S_WWAIT,
    S_PREAD,
    S_PWAIT,
    S_WRITE
  } conv_state_e;

  // Max pool with four read/wait pairs then one write per window
  typedef enum logic [2:0] {
    P_IDLE,
    P_READ,
    P_WAIT,
    P_WRITE,
    P_DONE
  } pool_state_e;

endpackage

`default_nettype wire

// ==== logic/convacc_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module convacc_top (
  input  wire logic                      clk,
  input  wire logic                      rst_i,
  input  wire convacc_pkg::layer_mode_e  mode_i,
  input  wire logic                      start_i,
  output logic                           busy_o,
  output logic                           done_o,
  output logic                           in_cs_o,
  output logic                           in_oe_o,
  output logic                           in_w_req_o,
  output sram_bus_pkg::sram_addr_t       in_addr_o,
  output sram_bus_pkg::sram_data_t       in_w_data_o,
  input  wire sram_bus_pkg::sram_data_t  in_r_data_i,
  output logic                           wt_cs_o,
  output logic                           wt_oe_o,
  output logic                           wt_w_req_o,
  output sram_bus_pkg::sram_addr_t       wt_addr_o,
  output sram_bus_pkg::sram_data_t       wt_w_data_o,
  input  wire sram_bus_pkg::sram_data_t  wt_r_data_i,
  output logic                           out_cs_o,
  output logic                           out_oe_o,
  output logic                           out_w_req_o,
  output sram_bus_pkg::sram_addr_t       out_addr_o,
  output sram_bus_pkg::sram_data_t       out_w_data_o,
  input  wire sram_bus_pkg::sram_data_t  out_r_data_i
);

  import convacc_pkg::*;
  import sram_bus_pkg::*;

  layer_mode_e mode_q;
  logic        busy_q;
  logic        go;

  logic       conv_en, conv_start, conv_done;
  logic       conv_wt_cs, conv_wt_oe, conv_in_cs, conv_in_oe;
  logic       conv_out_cs, conv_out_w_req;
  sram_addr_t conv_wt_addr, conv_in_addr, conv_out_addr;
  sram_data_t conv_wt_r_data, conv_in_r_data, conv_out_w_data;

  logic       pool_en, pool_start, pool_done;
  logic       pool_in_cs, pool_in_oe, pool_out_cs, pool_out_w_req;
  sram_addr_t pool_in_addr, pool_out_addr;
  sram_data_t pool_in_r_data, pool_out_w_data;

  // New layer only when idle and a real mode is asked for
  assign go = start_i && !busy_q && (mode_i != MODE_IDLE);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      mode_q <= MODE_IDLE;
      busy_q <= 1'b0;
    end else if (go) begin
      mode_q <= mode_i;
      busy_q <= 1'b1;
    end else if (done_o) begin
      busy_q <= 1'b0;
    end
  end

  assign busy_o = busy_q;

  conv_bus_switcher u_switcher (
    .clk               (clk),
    .rst_i             (rst_i),
    .mode_i            (mode_q),
    .start_i           (go),
    .done_o            (done_o),
    .ext_in_cs_o       (in_cs_o),
    .ext_in_oe_o       (in_oe_o),
    .ext_in_w_req_o    (in_w_req_o),
    .ext_in_addr_o     (in_addr_o),
    .ext_in_w_data_o   (in_w_data_o),
    .ext_in_r_data_i   (in_r_data_i),
    .ext_wt_cs_o       (wt_cs_o),
    .ext_wt_oe_o       (wt_oe_o),
    .ext_wt_w_req_o    (wt_w_req_o),
    .ext_wt_addr_o     (wt_addr_o),
    .ext_wt_w_data_o   (wt_w_data_o),
    .ext_wt_r_data_i   (wt_r_data_i),
    .ext_out_cs_o      (out_cs_o),
    .ext_out_oe_o      (out_oe_o),
    .ext_out_w_req_o   (out_w_req_o),
    .ext_out_addr_o    (out_addr_o),
    .ext_out_w_data_o  (out_w_data_o),
    .ext_out_r_data_i  (out_r_data_i),
    .conv_en_o         (conv_en),
    .conv_start_o      (conv_start),
    .conv_done_i       (conv_done),
    .conv_in_cs_i      (conv_in_cs),
    .conv_in_oe_i      (conv_in_oe),
    .conv_in_w_req_i   (1'b0),
    .conv_in_addr_i    (conv_in_addr),
    .conv_in_w_data_i  ('0),
    .conv_in_r_data_o  (conv_in_r_data),
    .conv_wt_cs_i      (conv_wt_cs),
    .conv_wt_oe_i      (conv_wt_oe),
    .conv_wt_w_req_i   (1'b0),
    .conv_wt_addr_i    (conv_wt_addr),
    .conv_wt_w_data_i  ('0),
    .conv_wt_r_data_o  (conv_wt_r_data),
    .conv_out_cs_i     (conv_out_cs),
    .conv_out_oe_i     (1'b0),
    .conv_out_w_req_i  (conv_out_w_req),
    .conv_out_addr_i   (conv_out_addr),
    .conv_out_w_data_i (conv_out_w_data),
    .conv_out_r_data_o (),
    .pool_en_o         (pool_en),
    .pool_start_o      (pool_start),
    .pool_done_i       (pool_done),
    .pool_in_cs_i      (pool_in_cs),
    .pool_in_oe_i      (pool_in_oe),
    .pool_in_w_req_i   (1'b0),
    .pool_in_addr_i    (pool_in_addr),
    .pool_in_w_data_i  ('0),
    .pool_in_r_data_o  (pool_in_r_data),
    .pool_out_cs_i     (pool_out_cs),
    .pool_out_oe_i     (1'b0),
    .pool_out_w_req_i  (pool_out_w_req),
    .pool_out_addr_i   (pool_out_addr),
    .pool_out_w_data_i (pool_out_w_data),
    .pool_out_r_data_o ()
  );

  conv_1x1_unit u_conv_1x1 (
    .clk          (clk),
    .rst_i        (rst_i),
    .en_i         (conv_en),
    .start_i      (conv_start),
    .done_o       (conv_done),
    .wt_cs_o      (conv_wt_cs),
    .wt_oe_o      (conv_wt_oe),
    .wt_addr_o    (conv_wt_addr),
    .wt_r_data_i  (conv_wt_r_data),
    .in_cs_o      (conv_in_cs),
    .in_oe_o      (conv_in_oe),
    .in_addr_o    (conv_in_addr),
    .in_r_data_i  (conv_in_r_data),
    .out_cs_o     (conv_out_cs),
    .out_w_req_o  (conv_out_w_req),
    .out_addr_o   (conv_out_addr),
    .out_w_data_o (conv_out_w_data)
  );

  maxpool_unit u_maxpool (
    .clk          (clk),
    .rst_i        (rst_i),
    .en_i         (pool_en),
    .start_i      (pool_start),
    .done_o       (pool_done),
    .in_cs_o      (pool_in_cs),
    .in_oe_o      (pool_in_oe),
    .in_addr_o    (pool_in_addr),
    .in_r_data_i  (pool_in_r_data),
    .out_cs_o     (pool_out_cs),
    .out_w_req_o  (pool_out_w_req),
    .out_addr_o   (pool_out_addr),
    .out_w_data_o (pool_out_w_data)
  );

endmodule

`default_nettype wire

// ==== logic/maxpool_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "convacc_params.svh"

module maxpool_unit (
  input  wire logic                      clk,
  input  wire logic                      rst_i,
  input  wire logic                      en_i,
  input  wire logic                      start_i,
  output logic                           done_o,
  output logic                           in_cs_o,
  output logic                           in_oe_o,
  output sram_bus_pkg::sram_addr_t       in_addr_o,
  input  wire sram_bus_pkg::sram_data_t  in_r_data_i,
  output logic                           out_cs_o,
  output logic                           out_w_req_o,
  output sram_bus_pkg::sram_addr_t       out_addr_o,
  output sram_bus_pkg::sram_data_t       out_w_data_o
);

  import convacc_pkg::*;
  import sram_bus_pkg::*;

  localparam int unsigned DIM      = `FMAP_DIM;
  localparam int unsigned HALF     = `FMAP_DIM / 2;
  localparam sram_addr_t  LAST_POS = sram_addr_t'(HALF - 1);

  pool_state_e state_q;
  sram_addr_t  orow_q;
  sram_addr_t  ocol_q;
  logic [1:0]  win_q;
  sram_data_t  max_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= P_IDLE;
      orow_q  <= '0;
      ocol_q  <= '0;
      win_q   <= '0;
    end else if (en_i) begin
      case (state_q)
        P_IDLE: begin
          if (start_i) begin
            orow_q  <= '0;
            ocol_q  <= '0;
            win_q   <= '0;
            state_q <= P_READ;
          end
        end
        P_READ: state_q <= P_WAIT;
        P_WAIT: begin
          // Window index wraps back to 0 after the fourth pixel
          win_q   <= win_q + 2'd1;
          state_q <= (win_q == 2'd3) ? P_WRITE : P_READ;
        end
        P_WRITE: begin
          if (orow_q == LAST_POS && ocol_q == LAST_POS) begin
            state_q <= P_DONE;
          end else begin
            state_q <= P_READ;
            if (ocol_q == LAST_POS) begin
              ocol_q <= '0;
              orow_q <= orow_q + 1'b1;
            end else begin
              ocol_q <= ocol_q + 1'b1;
            end
          end
        end
        P_DONE: state_q <= P_IDLE;
        default: state_q <= P_IDLE;
      endcase
    end
  end

  // Running unsigned max seeded by the first pixel of the window
  always_ff @(posedge clk) begin
    if (en_i && state_q == P_WAIT) begin
      if (win_q == 2'd0 || in_r_data_i > max_q) begin
        max_q <= in_r_data_i;
      end
    end
  end

  // Window pixels in row-major order with win_q[1] as the row
  assign in_cs_o   = (state_q == P_READ);
  assign in_oe_o   = (state_q == P_READ);
  assign in_addr_o = sram_addr_t'((2 * orow_q + win_q[1]) * DIM + 2 * ocol_q + win_q[0]);

  assign out_cs_o     = (state_q == P_WRITE);
  assign out_w_req_o  = (state_q == P_WRITE);
  assign out_addr_o   = sram_addr_t'(orow_q * HALF + ocol_q);
  assign out_w_data_o = max_q;

  assign done_o = (state_q == P_DONE);

endmodule

`default_nettype wire

// ==== logic/sram_bus_pkg.sv ====
`default_nettype none

`include "convacc_params.svh"

package sram_bus_pkg;

  // Word types shared by the input, weight and output buses
  typedef logic [`SRAM_AW-1:0] sram_addr_t;
  typedef logic [`SRAM_DW-1:0] sram_data_t;

endpackage

`default_nettype wire

// ==== project.f ====
+incdir+logic
logic/sram_bus_pkg.sv
logic/convacc_pkg.sv
logic/conv_bus_switcher.sv
logic/conv_1x1_unit.sv
logic/maxpool_unit.sv
logic/convacc_top.sv
dv/convacc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns --top-module convacc_tb \
  -f project.f --Mdir obj_dir -o convacc_sim > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/convacc_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
  exit 0
fi

echo "Pass line not found in sim.log"
exit 1
